// File: fpCmpUnit.f
+incdir+testbench
src/fpCmpPkg.sv
src/fpDecompose.sv
src/fpCompare.sv
src/fpClassify.sv
src/fpResult.sv
src/fpCmpUnit.sv
testbench/tbFpCmpUnit.sv

// File: runSim.sh
#!/bin/sh
# builds the compare unit testbench with Verilator, runs it, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tbFpCmpUnit \
  -f fpCmpUnit.f -o simFpCmpUnit > sim.log 2>&1 \
  && ./obj_dir/simFpCmpUnit >> sim.log 2>&1 \
  || echo "SIMULATION FAILED" >> sim.log
if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed, see sim.log"
exit 0

// File: src/fpClassify.sv
/*
  Ten-class classification of one decoded operand. Exactly one bit of the
  mask is set, at the positions given in the package. Combinational.
*/
`timescale 1ns/1ps

module fpClassify import fpCmpPkg::*; #(
  parameter int WID = 32
) (
  input  logic                  sgn,
  input  logic                  xz,     // exponent zero
  input  logic                  mz,     // mantissa zero
  input  logic                  xinf,   // exponent all ones
  input  logic                  snan,
  input  logic                  qnan,
  output logic [classWidth-1:0] classMask
);

  logic isZero;
  logic isSub;
  logic isNorm;
  logic isInf;

  // only half, single and double fields are decoded upstream
  if (WID != 16 && WID != 32 && WID != 64) begin : gUnsupported
    $error("fpClassify: unsupported width %0d", WID);
  end

  // ==========================================================================
  // value kind
  // ==========================================================================
  assign isZero = xz & mz;
  assign isSub  = xz & ~mz;           // subnormal, no hidden bit
  assign isNorm = ~xz & ~xinf;
  assign isInf  = xinf & mz;

  // ==========================================================================
  // one-hot mask
  // ==========================================================================
  always_comb begin
    classMask = '0;
    classMask[classNegInf]  = sgn & isInf;
    classMask[classNegNorm] = sgn & isNorm;
    classMask[classNegSub]  = sgn & isSub;
    classMask[classNegZero] = sgn & isZero;
    classMask[classPosZero] = ~sgn & isZero;
    classMask[classPosSub]  = ~sgn & isSub;
    classMask[classPosNorm] = ~sgn & isNorm;
    classMask[classPosInf]  = ~sgn & isInf;
    classMask[classSnan]    = snan;   // nans ignore the sign
    classMask[classQnan]    = qnan;
  end

endmodule

// File: src/fpCmpPkg.sv
/*
  Shared definitions for the floating-point compare and classify unit.
  Holds the operation codes, the class mask bit positions and the
  field-width functions that size the IEEE 754 fields from WID.
*/

package fpCmpPkg;

  // ==========================================================================
  // operation codes
  // ==========================================================================
  typedef enum logic [2:0] {
    opEq    = 3'd0,   // a == b, answer in bit 0
    opLt    = 3'd1,   // a < b
    opLe    = 3'd2,   // a <= b
    opMin   = 3'd3,   // minimum of a and b
    opMax   = 3'd4,   // maximum of a and b
    opClass = 3'd5    // ten-class mask of a
  } fpOp_t;

  // ==========================================================================
  // class mask, one-hot
  // ==========================================================================
  localparam int classWidth   = 10;

  localparam int classNegInf  = 0;
  localparam int classNegNorm = 1;
  localparam int classNegSub  = 2;
  localparam int classNegZero = 3;
  localparam int classPosZero = 4;
  localparam int classPosSub  = 5;
  localparam int classPosNorm = 6;
  localparam int classPosInf  = 7;
  localparam int classSnan    = 8;   // signaling nan, sign ignored
  localparam int classQnan    = 9;   // quiet nan, sign ignored

  // ==========================================================================
  // field widths per format
  // ==========================================================================

  // exponent width, half / single / double
  function automatic int expWidth(input int wid);
    case (wid)
      16:      return 5;
      32:      return 8;
      64:      return 11;
      default: return 8;   // falls back to single
    endcase
  endfunction

  // stored mantissa width, hidden bit not counted
  function automatic int fracWidth(input int wid);
    case (wid)
      16:      return 10;
      32:      return 23;
      64:      return 52;
      default: return 23;
    endcase
  endfunction

endpackage

// File: src/fpCmpUnit.sv
/*
  Floating-point compare and classify unit, top level. Decodes a and b,
  compares and classifies in the same cycle and registers the selected
  result one clock after an inValid strobe. No back-pressure.
*/
`timescale 1ns/1ps

module fpCmpUnit import fpCmpPkg::*; #(
  parameter  int WID   = 32,          // 16, 32 or 64
  localparam int expW  = expWidth(WID),
  localparam int fracW = fracWidth(WID)
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           inValid,
  input  fpOp_t          op,
  input  logic [WID-1:0] a,
  input  logic [WID-1:0] b,
  output logic           outValid,
  output logic [WID-1:0] result,
  output logic           invalid
);

  // decoded a, also feeds the classifier
  logic             aSgn, aXz, aMz, aVz, aXinf, aQnan, aSnan, aNan;
  logic [expW-1:0]  aExp;
  logic [fracW-1:0] aMan;

  // decoded b
  logic             bSgn, bVz, bSnan, bNan;
  logic [expW-1:0]  bExp;
  logic [fracW-1:0] bMan;

  // execute to result stage
  logic                  lt, eq, le;
  logic [WID-1:0]        minVal, maxVal;
  logic                  cmpInvalid, ordInvalid, minMaxInvalid;
  logic [classWidth-1:0] classMask;

  // ==========================================================================
  // decode
  // ==========================================================================
  fpDecompose #(.WID(WID)) decA (
    .operand(a), .sgn(aSgn), .exp(aExp), .man(aMan), .fract(),
    .xz(aXz), .mz(aMz), .vz(aVz), .inf(), .xinf(aXinf),
    .qnan(aQnan), .snan(aSnan), .nan(aNan)
  );

  fpDecompose #(.WID(WID)) decB (
    .operand(b), .sgn(bSgn), .exp(bExp), .man(bMan), .fract(),
    .xz(), .mz(), .vz(bVz), .inf(), .xinf(),
    .qnan(), .snan(bSnan), .nan(bNan)
  );

  // ==========================================================================
  // execute
  // ==========================================================================
  fpCompare #(.WID(WID)) uCompare (
    .aSgn(aSgn), .aMag({aExp, aMan}), .aVz(aVz), .aNan(aNan), .aSnan(aSnan),
    .bSgn(bSgn), .bMag({bExp, bMan}), .bVz(bVz), .bNan(bNan), .bSnan(bSnan),
    .lt(lt), .eq(eq), .le(le), .minVal(minVal), .maxVal(maxVal),
    .cmpInvalid(cmpInvalid), .ordInvalid(ordInvalid), .minMaxInvalid(minMaxInvalid)
  );

  fpClassify #(.WID(WID)) uClassify (
    .sgn(aSgn), .xz(aXz), .mz(aMz), .xinf(aXinf),
    .snan(aSnan), .qnan(aQnan), .classMask(classMask)
  );

  // ==========================================================================
  // result, the only registered stage
  // ==========================================================================
  fpResult #(.WID(WID)) uResult (
    .clk(clk), .rstN(rstN), .inValid(inValid), .op(op),
    .lt(lt), .eq(eq), .le(le), .minVal(minVal), .maxVal(maxVal),
    .classMask(classMask), .cmpInvalid(cmpInvalid), .ordInvalid(ordInvalid),
    .minMaxInvalid(minMaxInvalid),
    .outValid(outValid), .result(result), .invalid(invalid)
  );

endmodule

// File: src/fpCompare.sv
/*
  Ordered compares, minimum and maximum of two decoded operands.
  Magnitude is exponent and mantissa concatenated, so an unsigned compare
  orders finite values and infinities. Produces the invalid conditions
  for each operation group. Purely combinational.
*/
`timescale 1ns/1ps

module fpCompare import fpCmpPkg::*; #(
  parameter  int WID   = 32,
  localparam int expW  = expWidth(WID),
  localparam int fracW = fracWidth(WID)
) (
  input  logic           aSgn,
  input  logic [WID-2:0] aMag,          // exponent and mantissa of a
  input  logic           aVz,
  input  logic           aNan,
  input  logic           aSnan,
  input  logic           bSgn,
  input  logic [WID-2:0] bMag,
  input  logic           bVz,
  input  logic           bNan,
  input  logic           bSnan,
  output logic           lt,
  output logic           eq,
  output logic           le,
  output logic [WID-1:0] minVal,
  output logic [WID-1:0] maxVal,
  output logic           cmpInvalid,    // for eq
  output logic           ordInvalid,    // for lt and le
  output logic           minMaxInvalid  // for min and max
);

  logic           bothZero;   // +-0 against +-0
  logic           anyNan;
  logic           anySnan;
  logic           magLt;      // |a| < |b|
  logic           magGt;      // |a| > |b|
  logic           magEq;
  logic           rawLt;      // ordering ignoring nans
  logic           rawEq;
  logic           aBelow;     // a goes to minVal, with -0 below +0
  logic [WID-1:0] aVal;
  logic [WID-1:0] bVal;
  logic [WID-1:0] canonNan;

  // ==========================================================================
  // ordering
  // ==========================================================================
  assign bothZero = aVz & bVz;
  assign anyNan   = aNan | bNan;
  assign anySnan  = aSnan | bSnan;

  assign magLt = aMag < bMag;
  assign magGt = aMag > bMag;
  assign magEq = aMag == bMag;

  // two zeros are equal whatever their signs
  assign rawEq = bothZero | ((aSgn == bSgn) & magEq);

  always_comb begin
    if (bothZero) begin
      rawLt = 1'b0;
    end else if (aSgn != bSgn) begin
      rawLt = aSgn;                 // negative a sits below positive b
    end else if (!aSgn) begin
      rawLt = magLt;                // both positive
    end else begin
      rawLt = magGt;                // both negative, larger magnitude is smaller
    end
  end

  // a nan operand is unordered, every answer drops to 0
  assign eq = rawEq & ~anyNan;
  assign lt = rawLt & ~anyNan;
  assign le = (rawLt | rawEq) & ~anyNan;

  // ==========================================================================
  // minimum and maximum
  // ==========================================================================
  assign aVal = {aSgn, aMag};
  assign bVal = {bSgn, bMag};

  // quiet nan, sign 0, only the top mantissa bit set
  assign canonNan = {1'b0, {expW{1'b1}}, 1'b1, {(fracW-1){1'b0}}};

  // signed zeros break the tie here and only here
  assign aBelow = rawLt | (bothZero & aSgn & ~bSgn);

  always_comb begin
    if (aNan & bNan) begin
      minVal = canonNan;
      maxVal = canonNan;
    end else if (aNan) begin
      minVal = bVal;                // one nan, hand back the number
      maxVal = bVal;
    end else if (bNan) begin
      minVal = aVal;
      maxVal = aVal;
    end else if (aBelow) begin
      minVal = aVal;
      maxVal = bVal;
    end else begin
      minVal = bVal;                // equal values land here too
      maxVal = aVal;
    end
  end

  // ==========================================================================
  // invalid conditions
  // ==========================================================================
  assign cmpInvalid    = anySnan;   // quiet eq, only snan traps
  assign ordInvalid    = anyNan;    // signaling lt/le, any nan traps
  assign minMaxInvalid = anySnan;

endmodule

// File: src/fpDecompose.sv
/*
  Splits one IEEE 754 operand into sign, exponent and mantissa, recovers
  the hidden bit and flags the special values. Purely combinational,
  one instance per operand.
*/
`timescale 1ns/1ps

module fpDecompose import fpCmpPkg::*; #(
  parameter  int WID   = 32,
  localparam int expW  = expWidth(WID),
  localparam int fracW = fracWidth(WID)
) (
  input  logic [WID-1:0]   operand,
  output logic             sgn,
  output logic [expW-1:0]  exp,
  output logic [fracW-1:0] man,
  output logic [fracW:0]   fract,   // mantissa with hidden bit restored
  output logic             xz,      // exponent is zero
  output logic             mz,      // mantissa is zero
  output logic             vz,      // value is zero
  output logic             inf,     // infinity
  output logic             xinf,    // exponent all ones
  output logic             qnan,    // quiet nan
  output logic             snan,    // signaling nan
  output logic             nan      // either kind of nan
);

  // ==========================================================================
  // field split
  // ==========================================================================
  assign sgn = operand[WID-1];
  assign exp = operand[WID-2 -: expW];
  assign man = operand[fracW-1:0];

  // hidden bit is one unless the number is subnormal or zero
  assign fract = {~xz, man};

  // ==========================================================================
  // special-value flags
  // ==========================================================================
  assign xz   = ~|exp;
  assign mz   = ~|man;
  assign vz   = xz & mz;            // +0 or -0
  assign xinf = &exp;

  assign inf  = xinf & mz;          // all ones exponent, empty mantissa
  assign nan  = xinf & ~mz;

  // top mantissa bit picks quiet vs signaling
  assign qnan = xinf &  man[fracW-1];
  assign snan = xinf & ~man[fracW-1] & ~mz;

endmodule

// File: src/fpResult.sv
/*
  Result stage. Picks the answer and the invalid condition that match the
  operation and registers them on a strobe. outValid follows inValid one
  clock later, result and invalid hold between strobes.
*/
`timescale 1ns/1ps

module fpResult import fpCmpPkg::*; #(
  parameter int WID = 32
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  inValid,
  input  fpOp_t                 op,
  input  logic                  lt,
  input  logic                  eq,
  input  logic                  le,
  input  logic [WID-1:0]        minVal,
  input  logic [WID-1:0]        maxVal,
  input  logic [classWidth-1:0] classMask,
  input  logic                  cmpInvalid,
  input  logic                  ordInvalid,
  input  logic                  minMaxInvalid,
  output logic                  outValid,
  output logic [WID-1:0]        result,
  output logic                  invalid
);

  logic [WID-1:0] selResult;
  logic           selInvalid;

  // ==========================================================================
  // operation select
  // ==========================================================================
  always_comb begin
    selResult  = '0;                  // compares use bit 0 only
    selInvalid = 1'b0;
    case (op)
      opEq:    begin selResult[0] = eq; selInvalid = cmpInvalid; end
      opLt:    begin selResult[0] = lt; selInvalid = ordInvalid; end
      opLe:    begin selResult[0] = le; selInvalid = ordInvalid; end
      opMin:   begin selResult = minVal; selInvalid = minMaxInvalid; end
      opMax:   begin selResult = maxVal; selInvalid = minMaxInvalid; end
      opClass: selResult = {{(WID-classWidth){1'b0}}, classMask};  // never invalid
      default: ;
    endcase
  end

  // ==========================================================================
  // output registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      result   <= '0;
      invalid  <= 1'b0;
    end else begin
      outValid <= inValid;            // strobe every cycle
      if (inValid) begin
        result  <= selResult;
        invalid <= selInvalid;
      end
    end
  end

endmodule

// File: testbench/tbFpCmpVectors.svh
/*
  Directed vectors and a single precision reference model for the compare
  unit testbench. Included inside the testbench module after WID is set.
*/
`ifndef TB_FP_CMP_VECTORS_SVH
`define TB_FP_CMP_VECTORS_SVH

typedef struct packed {
  fpOp_t       op;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;   // expected result
  logic        inv;   // expected invalid
} vecRow_t;

vecRow_t vecTable[$];

// ============================================================================
// reference model, single precision fields
// ============================================================================
function automatic logic isNan(input logic [31:0] x);
  return (x[30:23] == 8'hff) && (|x[22:0]);
endfunction

function automatic logic isSignaling(input logic [31:0] x);
  return isNan(x) && !x[22];       // quiet bit clear
endfunction

function automatic logic isZero(input logic [31:0] x);
  return x[30:0] == 31'h0;
endfunction

// maps a value onto an unsigned key that sorts like the real line, -0 below +0
function automatic logic [31:0] orderKey(input logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic logic equalTo(input logic [31:0] x, input logic [31:0] y);
  if (isNan(x) || isNan(y)) return 1'b0;
  if (isZero(x) && isZero(y)) return 1'b1;
  return x == y;
endfunction

function automatic logic lessThan(input logic [31:0] x, input logic [31:0] y);
  if (isNan(x) || isNan(y) || (isZero(x) && isZero(y))) return 1'b0;
  return orderKey(x) < orderKey(y);
endfunction

function automatic logic [31:0] pickMin(input logic [31:0] x, input logic [31:0] y);
  if (isNan(x) && isNan(y)) return 32'h7fc0_0000;
  if (isNan(x)) return y;
  if (isNan(y)) return x;
  return (orderKey(x) <= orderKey(y)) ? x : y;
endfunction

function automatic logic [31:0] pickMax(input logic [31:0] x, input logic [31:0] y);
  if (isNan(x) && isNan(y)) return 32'h7fc0_0000;
  if (isNan(x)) return y;
  if (isNan(y)) return x;
  return (orderKey(x) >= orderKey(y)) ? x : y;
endfunction

function automatic logic [31:0] classOf(input logic [31:0] x);
  int idx;
  if (x[30:23] == 8'hff) begin
    if (x[22:0] == 23'h0) idx = x[31] ? classNegInf : classPosInf;
    else idx = x[22] ? classQnan : classSnan;
  end else if (x[30:23] == 8'h00) begin
    if (x[22:0] == 23'h0) idx = x[31] ? classNegZero : classPosZero;
    else idx = x[31] ? classNegSub : classPosSub;
  end else begin
    idx = x[31] ? classNegNorm : classPosNorm;
  end
  return 32'd1 << idx;
endfunction

task automatic modelOp(input fpOp_t o, input logic [31:0] x, input logic [31:0] y,
                       output logic [31:0] res, output logic inv);
  res = '0;
  inv = 1'b0;
  case (o)
    opEq: begin
      res[0] = equalTo(x, y);
      inv    = isSignaling(x) | isSignaling(y);   // quiet compare
    end
    opLt: begin
      res[0] = lessThan(x, y);
      inv    = isNan(x) | isNan(y);
    end
    opLe: begin
      res[0] = lessThan(x, y) | equalTo(x, y);
      inv    = isNan(x) | isNan(y);
    end
    opMin: begin
      res = pickMin(x, y);
      inv = isSignaling(x) | isSignaling(y);
    end
    opMax: begin
      res = pickMax(x, y);
      inv = isSignaling(x) | isSignaling(y);
    end
    opClass: res = classOf(x);
    default: ;
  endcase
endtask

// ============================================================================
// directed table, expected values worked out by hand
// ============================================================================
task automatic addRow(input fpOp_t o, input logic [31:0] x, input logic [31:0] y,
                      input logic [31:0] res, input logic inv);
  vecTable.push_back('{o, x, y, res, inv});
endtask

task automatic loadTable();
  addRow(opEq,  32'h3f80_0000, 32'h3f80_0000, 32'h1, 1'b0);   // 1 == 1
  addRow(opEq,  32'h0000_0000, 32'h8000_0000, 32'h1, 1'b0);   // +0 == -0
  addRow(opEq,  32'h3f80_0000, 32'h4000_0000, 32'h0, 1'b0);
  addRow(opEq,  32'h7fc0_0000, 32'h7fc0_0000, 32'h0, 1'b0);   // qnan is quiet
  addRow(opEq,  32'h7f80_0001, 32'h3f80_0000, 32'h0, 1'b1);   // snan traps
  addRow(opEq,  32'h7f80_0000, 32'h7f80_0000, 32'h1, 1'b0);
  addRow(opLt,  32'hbf80_0000, 32'h3f80_0000, 32'h1, 1'b0);
  addRow(opLt,  32'h8000_0000, 32'h0000_0000, 32'h0, 1'b0);   // -0 not below +0
  addRow(opLt,  32'h0000_0001, 32'h4000_0000, 32'h1, 1'b0);   // subnormal
  addRow(opLt,  32'hff80_0000, 32'h8000_0001, 32'h1, 1'b0);
  addRow(opLt,  32'h7fc0_0000, 32'h3f80_0000, 32'h0, 1'b1);   // qnan traps here
  addRow(opLt,  32'h4000_0000, 32'h3f80_0000, 32'h0, 1'b0);
  addRow(opLt,  32'hbf80_0000, 32'hc000_0000, 32'h0, 1'b0);   // -1 above -2
  addRow(opLe,  32'h0000_0000, 32'h8000_0000, 32'h1, 1'b0);
  addRow(opLe,  32'h3f80_0000, 32'h3f80_0000, 32'h1, 1'b0);
  addRow(opLe,  32'h4000_0000, 32'h3f80_0000, 32'h0, 1'b0);
  addRow(opLe,  32'h3f80_0000, 32'h7fc0_0000, 32'h0, 1'b1);
  addRow(opLe,  32'h7f7f_ffff, 32'h7f80_0000, 32'h1, 1'b0);   // max normal vs inf
  addRow(opMin, 32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, 1'b0);
  addRow(opMin, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 1'b0);
  addRow(opMin, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0);
  addRow(opMin, 32'h7fc0_0000, 32'h4000_0000, 32'h4000_0000, 1'b0);
  addRow(opMin, 32'h7f80_0001, 32'hbf80_0000, 32'hbf80_0000, 1'b1);
  addRow(opMin, 32'h7fc0_0000, 32'h7f80_0001, 32'h7fc0_0000, 1'b1);
  addRow(opMax, 32'h3f80_0000, 32'h4000_0000, 32'h4000_0000, 1'b0);
  addRow(opMax, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
  addRow(opMax, 32'hff80_0000, 32'h7fc0_0000, 32'hff80_0000, 1'b0);
  addRow(opMax, 32'hffc0_0000, 32'h7fc0_0001, 32'h7fc0_0000, 1'b0);   // two nans
  addRow(opMax, 32'hbf80_0000, 32'hc000_0000, 32'hbf80_0000, 1'b0);
  addRow(opClass, 32'hff80_0000, 32'h0, 32'h0000_0001, 1'b0);
  addRow(opClass, 32'hc000_0000, 32'h0, 32'h0000_0002, 1'b0);
  addRow(opClass, 32'h8000_0001, 32'h0, 32'h0000_0004, 1'b0);
  addRow(opClass, 32'h8000_0000, 32'h0, 32'h0000_0008, 1'b0);
  addRow(opClass, 32'h0000_0000, 32'h0, 32'h0000_0010, 1'b0);
  addRow(opClass, 32'h0000_0001, 32'h0, 32'h0000_0020, 1'b0);
  addRow(opClass, 32'h3f80_0000, 32'h0, 32'h0000_0040, 1'b0);
  addRow(opClass, 32'h7f80_0000, 32'h0, 32'h0000_0080, 1'b0);
  addRow(opClass, 32'h7f80_0001, 32'h0, 32'h0000_0100, 1'b0);   // snan, no trap
  addRow(opClass, 32'h7fc0_0000, 32'h0, 32'h0000_0200, 1'b0);
endtask

`endif

// File: testbench/tbFpCmpUnit.sv
/*
  Testbench for the compare and classify unit at single precision. Runs the
  directed table, then a biased random sweep checked against the model.
*/
`timescale 1ns/1ps

module tbFpCmpUnit import fpCmpPkg::*; ();

  localparam int WID        = 32;
  localparam int randPerOp  = 200;     // random pairs per operation

  logic           clk = 1'b0;
  logic           rstN;
  logic           inValid;
  fpOp_t          op;
  logic [WID-1:0] a;
  logic [WID-1:0] b;
  logic           outValid;
  logic [WID-1:0] result;
  logic           invalid;

  logic           pendValid;           // outValid expected at next check
  logic [WID-1:0] lastRes;             // value result must hold
  logic           lastInv;
  logic [WID-1:0] expResQ[$];          // one deep as result lags a cycle
  logic           expInvQ[$];
  logic [31:0]    rngState = 32'hea4da73d;
  int             cycleCount = 0;
  int             cycleLimit = 0;

  `include "tbFpCmpVectors.svh"

  fpCmpUnit #(.WID(WID)) u_fpCmpUnit (
    .clk(clk), .rstN(rstN), .inValid(inValid), .op(op), .a(a), .b(b),
    .outValid(outValid), .result(result), .invalid(invalid)
  );

  always #5 clk = ~clk;                // 10 ns period

  // ==========================================================================
  // timeout
  // ==========================================================================
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped on timeout");
    end
  end

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic checkResult(input logic [WID-1:0] expVal, input logic [WID-1:0] actVal);
    if (actVal !== expVal) begin
      $display("ERROR result: expected %h, got %h (op %s, a %h, b %h)",
               expVal, actVal, op.name(), a, b);
      $display("SIMULATION FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic checkFlag(input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("ERROR invalid: expected %h, got %h (op %s, a %h, b %h)",
               expVal, actVal, op.name(), a, b);
      $display("SIMULATION FAILED");
      $fatal(1, "invalid mismatch");
    end
  endtask

  task automatic checkValid(input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("ERROR outValid: expected %h, got %h", expVal, actVal);
      $display("SIMULATION FAILED");
      $fatal(1, "outValid mismatch");
    end
  endtask

  // ==========================================================================
  // stimulus helpers
  // ==========================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drawRand(output logic [31:0] r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  // exponent pulled toward all ones and zero so specials show up often
  function automatic logic [31:0] biasOperand(input logic [31:0] r1, input logic [31:0] r2);
    logic [7:0]  e;
    logic [22:0] m;
    case (r1[1:0])
      2'd0:    e = 8'hff;              // inf and nan
      2'd1:    e = 8'h00;              // zero and subnormal
      default: e = r1[9:2];
    endcase
    m = (r2[1:0] == 2'd0) ? 23'h0 : r2[31:9];
    return {r1[31], e, m};
  endfunction

  // checks last cycle's outputs at the falling edge and drives the next inputs
  task automatic stepCycle(input logic strobe, input fpOp_t nextOp,
                           input logic [WID-1:0] nextA, input logic [WID-1:0] nextB,
                           input logic [WID-1:0] nextRes, input logic nextInv);
    @(negedge clk);
    checkValid(pendValid, outValid);
    if (expResQ.size() > 0) begin
      lastRes = expResQ.pop_front();
      lastInv = expInvQ.pop_front();
    end
    checkResult(lastRes, result);      // also covers hold between strobes
    checkFlag(lastInv, invalid);
    inValid   = strobe;
    pendValid = strobe;
    op        = nextOp;                // driven on idle cycles too
    a         = nextA;
    b         = nextB;
    if (strobe) begin
      expResQ.push_back(nextRes);
      expInvQ.push_back(nextInv);
    end
  endtask

  // idle inputs select another result and raise invalid
  // so a register that fails to hold shows up at the next check
  task automatic idleCycle();
    stepCycle(1'b0, opMax, 32'h7f80_0001, 32'hdead_beef, '0, 1'b0);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    vecRow_t     row;
    fpOp_t       curOp;
    logic [31:0] r1, r2, r3, r4, r5;
    logic [31:0] ra, rb, expRes;
    logic        expInv;
    rstN      = 1'b0;
    inValid   = 1'b0;
    op        = opEq;
    a         = '0;
    b         = '0;
    pendValid = 1'b0;
    lastRes   = '0;                    // reset value of result
    lastInv   = 1'b0;
    loadTable();
    cycleLimit = 2 * (vecTable.size() + 6 * randPerOp) + 20;

    idleCycle();                       // two cycles in reset
    idleCycle();
    rstN = 1'b1;

    for (int i = 0; i < vecTable.size(); i++) begin
      row = vecTable[i];
      stepCycle(1'b1, row.op, row.a, row.b, row.res, row.inv);
      if (i % 7 == 6) idleCycle();     // gap in the strobe train
    end

    for (int k = 0; k < 6; k++) begin
      curOp = fpOp_t'(k);
      for (int n = 0; n < randPerOp; n++) begin
        drawRand(r1);
        drawRand(r2);
        drawRand(r3);
        drawRand(r4);
        drawRand(r5);
        ra = biasOperand(r1, r2);
        rb = biasOperand(r3, r4);
        if (r5[2:0] == 3'd0) rb = ra;                         // exact tie
        else if (r5[2:0] == 3'd1) rb = ra ^ 32'h8000_0000;    // opposite sign
        modelOp(curOp, ra, rb, expRes, expInv);
        stepCycle(1'b1, curOp, ra, rb, expRes, expInv);
        if (r5[5:3] == 3'd0) idleCycle();
      end
    end

    idleCycle();                       // drain the last result
    idleCycle();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
